//--- files.f
hdl/rv_core_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/execute_unit.sv
hdl/mem_writeback.sv
hdl/rv_core_top.sv
tests/rv_core_checker.sv
tests/rv_core_monitor.sv
tests/rv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module rv_core_tb \
    -o rv_core_sim \
    && ./obj_dir/rv_core_sim | awk '{ print } /TB PASSED/ { ok = 1 } END { exit !ok }' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tests/rv_core_tb.sv
/* runs a table of short programs on the core at reset_pc 0
   each program ends in a store to 0x200+4*index and a self-loop */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    localparam int n_tests     = 23;
    localparam int prog_len    = 8;
    localparam int watchdog_ns = n_tests * prog_len * 4 * 20 * 4;
    localparam logic [31:0] self_loop = 32'h0000_006f;   // jal x0,0

    logic        clk;
    logic        reset;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic        dmem_req;
    logic        dmem_we;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        retire;

    logic [31:0] imem [64];
    logic [31:0] dmem [256];
    logic [63:0] names [n_tests];
    logic [31:0] progs [n_tests][prog_len];
    logic [31:0] exp_vals [n_tests];
    logic [31:0] exp_rets [n_tests];
    int          n_def;
    int          pos;
    logic [63:0] cur_name;
    logic [31:0] cur_addr;
    logic [31:0] cur_data;
    logic [31:0] cur_rets;
    logic        seen;
    int          pass_count;
    int          fail_count;

    rv_core_top #(.reset_pc(32'h0)) dut0 (
        .clk (clk), .reset (reset), .imem_req (imem_req), .imem_addr (imem_addr),
        .imem_rdata (imem_rdata), .dmem_req (dmem_req), .dmem_we (dmem_we),
        .dmem_addr (dmem_addr), .dmem_wdata (dmem_wdata), .dmem_rdata (dmem_rdata),
        .retire (retire)
    );

    rv_core_monitor mon0 (
        .clk (clk), .reset (reset), .dmem_req (dmem_req), .dmem_we (dmem_we),
        .dmem_addr (dmem_addr), .dmem_wdata (dmem_wdata), .retire (retire),
        .test_name (cur_name), .exp_addr (cur_addr), .exp_data (cur_data),
        .exp_retires (cur_rets), .seen (seen),
        .pass_count (pass_count), .fail_count (fail_count)
    );

    bind rv_core_top rv_core_checker chk0 (
        .clk (clk), .reset (reset), .imem_req (imem_req), .dmem_req (dmem_req),
        .dmem_we (dmem_we), .retire (retire)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // both memories answer one cycle after the request
    always @(posedge clk) begin
        if (imem_req)
            imem_rdata <= imem[imem_addr[7:2]];
        if (dmem_req) begin
            if (dmem_we)
                dmem[dmem_addr[9:2]] <= dmem_wdata;
            dmem_rdata <= dmem[dmem_addr[9:2]];
        end
    end

    // rv32i encoders
    function automatic logic [31:0] enc_r(input int f7, input int f3, input int rd,
                                          input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                          input int rd, input int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_u(input int imm20, input int rd, input int op);
        return {imm20[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return enc_i(imm, rs1, 0, rd, 'h13);
    endfunction

    function automatic int check_addr(input int i);
        return 'h200 + 4 * i;
    endfunction

    // retires counts the instructions completed up to and including the result store
    task automatic new_test(input logic [63:0] name, input logic [31:0] expected,
                            input int retires);
        names[n_def]    = name;
        exp_vals[n_def] = expected;
        exp_rets[n_def] = retires;
        pos = 0;
        for (int k = 0; k < prog_len; k++)
            progs[n_def][k] = self_loop;
    endtask

    task automatic emit(input logic [31:0] word);
        progs[n_def][pos] = word;
        pos++;
    endtask

    // result store and self-loop
    task automatic close_test(input int rs);
        emit(enc_s(check_addr(n_def), rs, 0));
        emit(self_loop);
        n_def++;
    endtask

    task automatic reg_test(input logic [63:0] name, input int f7, input int f3,
                            input int a, input int b, input logic [31:0] expected);
        new_test(name, expected, 4);
        emit(addi(1, 0, a));
        emit(addi(2, 0, b));
        emit(enc_r(f7, f3, 3, 1, 2));
        close_test(3);
    endtask

    // marker 0xaa if taken, 0xbb if the fall-through addi ran
    task automatic branch_test(input logic [63:0] name, input int f3, input int a,
                               input int b, input logic taken);
        new_test(name, taken ? 32'haa : 32'hbb, taken ? 5 : 6);
        emit(addi(1, 0, a));
        emit(addi(2, 0, b));
        emit(addi(3, 0, 'haa));
        emit(enc_b(8, 2, 1, f3));
        emit(addi(3, 0, 'hbb));
        close_test(3);
    endtask

    task automatic build_table;
        n_def = 0;
        new_test("addi", 32'd95, 3);
        emit(addi(1, 0, -5));
        emit(addi(2, 1, 100));
        close_test(2);
        reg_test("sub",  'h20, 0, 7, 20, 32'hffff_fff3);
        reg_test("xor",  0, 4, 'h5a5, 'h0ff, 32'h0000_055a);
        reg_test("or",   0, 6, 'h5a5, 'h0ff, 32'h0000_05ff);
        reg_test("and",  0, 7, 'h5a5, 'h0ff, 32'h0000_00a5);
        reg_test("sll",  0, 1, 3, 5, 32'h0000_0060);
        reg_test("srl",  0, 5, -16, 4, 32'h0fff_ffff);
        reg_test("sra",  'h20, 5, -16, 4, 32'hffff_ffff);
        reg_test("slt",  0, 2, -1, 1, 32'd1);
        reg_test("sltu", 0, 3, -1, 1, 32'd0);
        new_test("lui", 32'h1234_5000, 2);
        emit(enc_u('h12345, 1, 'h37));
        close_test(1);
        new_test("auipc", 32'h0000_1004, 3);
        emit(addi(0, 0, 0));
        emit(enc_u('h1, 1, 'h17));
        close_test(1);
        branch_test("beq_tkn",  0, 1, 1, 1'b1);
        branch_test("beq_nt",   0, 1, 2, 1'b0);
        branch_test("bne_tkn",  1, 1, 2, 1'b1);
        branch_test("bne_nt",   1, 1, 1, 1'b0);
        branch_test("blt_tkn",  4, -1, 1, 1'b1);
        branch_test("blt_nt",   4, 1, -1, 1'b0);
        branch_test("bgeu_tkn", 7, -1, 1, 1'b1);
        branch_test("bgeu_nt",  7, 1, -1, 1'b0);
        new_test("jal", 32'd4, 2);
        emit(enc_j(8, 1));
        emit(addi(1, 0, 'h77));
        close_test(1);
        new_test("jalr", 32'd8, 3);
        emit(addi(5, 0, 12));
        emit(enc_i(5, 5, 0, 1, 'h67));   // target 17, lands on 16
        emit(addi(1, 0, 'h77));
        emit(addi(1, 0, 'h66));
        close_test(1);
        new_test("lw_sw", 32'h0000_0123, 6);
        emit(addi(1, 0, 'h123));
        emit(enc_s('h300, 1, 0));
        emit(enc_i('h300, 0, 2, 2, 'h03));
        emit(addi(0, 0, 7));             // x0 must stay zero
        emit(enc_r(0, 0, 3, 2, 0));
        close_test(3);
    endtask

    task automatic run_test(input int i);
        @(posedge clk);
        reset    <= 1'b1;
        cur_name <= names[i];
        cur_addr <= check_addr(i);
        cur_data <= exp_vals[i];
        cur_rets <= exp_rets[i];
        for (int k = 0; k < 64; k++)
            imem[k] = (k < prog_len) ? progs[i][k] : self_loop;
        for (int k = 0; k < 256; k++)
            dmem[k] = $urandom();
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        while (!seen)
            @(posedge clk);
    endtask

    initial begin
        reset      = 1'b1;
        imem_rdata = '0;
        dmem_rdata = '0;
        cur_name   = '0;
        cur_addr   = '0;
        cur_data   = '0;
        cur_rets   = '0;
        void'($urandom(33217));
        build_table();
        for (int i = 0; i < n_tests; i++)
            run_test(i);
        @(posedge clk);   // let the last count settle
        $display("tests run: %0d, passed: %0d, failed: %0d", n_tests, pass_count, fail_count);
        if (fail_count == 0 && pass_count == n_tests) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired: the core stopped producing result stores");
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/rv_core_monitor.sv
/* checks the first dmem write to the check address and the retire count up to it
   writes into the 0x300 page are scratch stores and are not compared */
`timescale 1ns/1ps
`default_nettype none

module rv_core_monitor (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        dmem_req,
    input  wire logic        dmem_we,
    input  wire logic [31:0] dmem_addr,
    input  wire logic [31:0] dmem_wdata,
    input  wire logic        retire,
    input  wire logic [63:0] test_name,
    input  wire logic [31:0] exp_addr,
    input  wire logic [31:0] exp_data,
    input  wire logic [31:0] exp_retires,
    output logic             seen,
    output int               pass_count,
    output int               fail_count
);

    int passes  = 0;
    int fails   = 0;
    int retires = 0;   // completed instructions since reset

    always @(posedge clk) begin
        if (reset) begin
            seen    <= 1'b0;
            retires <= 0;
        end else begin
            if (retire)
                retires <= retires + 1;
            if (dmem_req && dmem_we) begin
                if (dmem_addr == exp_addr) begin
                    if (!seen) begin
                        seen <= 1'b1;   // one verdict per test
                        if (dmem_wdata != exp_data) begin
                            fails <= fails + 1;
                            $display("[ERROR] %0s: expected %h, actual %h",
                                     test_name, exp_data, dmem_wdata);
                        end else if (retires + (retire ? 1 : 0) != exp_retires) begin
                            fails <= fails + 1;   // the store retires in this cycle
                            $display("[ERROR] %0s retires: expected %0d, actual %0d",
                                     test_name, exp_retires, retires + (retire ? 1 : 0));
                        end else begin
                            passes <= passes + 1;
                            $display("test %0s: ok, stored %h", test_name, dmem_wdata);
                        end
                    end
                end else if (dmem_addr[31:8] != 24'h3) begin
                    fails <= fails + 1;
                    $display("test %0s: store went to address %h instead of %h",
                             test_name, dmem_addr, exp_addr);
                end
            end
        end
    end

    assign pass_count = passes;
    assign fail_count = fails;

endmodule

`default_nettype wire

//--- tests/rv_core_checker.sv
/* protocol assertions on the core's external ports, bound to rv_core_top
   assumes synchronous active-high reset and one-cycle memory answers */
`timescale 1ns/1ps
`default_nettype none

module rv_core_checker (
    input wire logic clk,
    input wire logic reset,
    input wire logic imem_req,
    input wire logic dmem_req,
    input wire logic dmem_we,
    input wire logic retire
);

    // every instruction takes at least three cycles
    a_retire_single : assert property (@(posedge clk) disable iff (reset)
        retire |=> !retire)
        else $error("retire was high on two consecutive cycles");

    a_we_has_req : assert property (@(posedge clk) disable iff (reset)
        dmem_we |-> dmem_req)
        else $error("dmem_we raised without dmem_req");

    a_fetch_not_retire : assert property (@(posedge clk) disable iff (reset)
        !(imem_req && retire))
        else $error("imem_req and retire were high in the same cycle");

    // the cycle after a reset edge must be quiet on every port
    a_quiet_reset : assert property (@(posedge clk)
        $past(reset) |-> !imem_req && !dmem_req && !dmem_we && !retire)
        else $error("request or retire seen during reset");

endmodule

`default_nettype wire

//--- hdl/rv_core_top.sv
/* rv32i core top, multi-cycle; no back-pressure on either memory port
   both memories must answer exactly one cycle after their request */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
    parameter logic [rv_core_pkg::xlen-1:0] reset_pc = 32'h8000_0000
) (
    input  wire logic                         clk,
    input  wire logic                         reset,
    output logic                              imem_req,
    output logic [rv_core_pkg::xlen-1:0]      imem_addr,
    input  wire logic [rv_core_pkg::xlen-1:0] imem_rdata,
    output logic                              dmem_req,
    output logic                              dmem_we,
    output logic [rv_core_pkg::xlen-1:0]      dmem_addr,
    output logic [rv_core_pkg::xlen-1:0]      dmem_wdata,
    input  wire logic [rv_core_pkg::xlen-1:0] dmem_rdata,
    output logic                              retire
);
    import rv_core_pkg::*;

    inst_u                 inst;
    logic [xlen-1:0]       pc, next_pc, snpc, imm, alu_result;
    logic [xlen-1:0]       rdata1, rdata2, rf_wdata;
    logic [reg_addr_w-1:0] rs1, rs2, rd;
    alu_op_t               alu_op;
    logic                  exec, done, rf_we;
    logic                  is_branch, is_jal, is_jalr, is_load, is_store;
    logic                  is_lui, is_auipc, writes_rd, use_imm;

    fetch_unit #(
        .reset_pc (reset_pc)
    ) u_fetch (
        .clk (clk), .reset (reset), .done (done), .next_pc (next_pc),
        .imem_rdata (imem_rdata), .imem_req (imem_req), .imem_addr (imem_addr),
        .pc (pc), .inst (inst), .exec (exec)
    );

    decode_unit u_decode (
        .inst (inst), .rs1 (rs1), .rs2 (rs2), .rd (rd), .imm (imm), .alu_op (alu_op),
        .is_branch (is_branch), .is_jal (is_jal), .is_jalr (is_jalr),
        .is_load (is_load), .is_store (is_store), .is_lui (is_lui),
        .is_auipc (is_auipc), .writes_rd (writes_rd), .use_imm (use_imm)
    );

    reg_file u_regs (
        .clk (clk), .reset (reset), .we (rf_we), .waddr (rd), .wdata (rf_wdata),
        .raddr1 (rs1), .raddr2 (rs2), .rdata1 (rdata1), .rdata2 (rdata2)
    );

    execute_unit u_exec (
        .pc (pc), .imm (imm), .rdata1 (rdata1), .rdata2 (rdata2), .alu_op (alu_op),
        .funct3 (inst.b_fmt.funct3),   // branch condition field
        .is_branch (is_branch), .is_jal (is_jal), .is_jalr (is_jalr),
        .is_lui (is_lui), .is_auipc (is_auipc), .use_imm (use_imm),
        .alu_result (alu_result), .next_pc (next_pc), .snpc (snpc)
    );

    mem_writeback u_mem_wb (
        .clk (clk), .reset (reset), .exec (exec), .is_load (is_load),
        .is_store (is_store), .writes_rd (writes_rd), .is_jal (is_jal),
        .is_jalr (is_jalr), .alu_result (alu_result), .snpc (snpc),
        .rdata2 (rdata2), .dmem_rdata (dmem_rdata), .dmem_req (dmem_req),
        .dmem_we (dmem_we), .dmem_addr (dmem_addr), .dmem_wdata (dmem_wdata),
        .rf_we (rf_we), .rf_wdata (rf_wdata), .retire (retire), .done (done)
    );

endmodule

`default_nettype wire

//--- hdl/mem_writeback.sv
/* data access and register write-back; dmem answers one cycle after dmem_req
   loads take one extra LOAD cycle, everything else finishes in EXEC */
`timescale 1ns/1ps
`default_nettype none

module mem_writeback (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         exec,
    input  wire logic                         is_load,
    input  wire logic                         is_store,
    input  wire logic                         writes_rd,
    input  wire logic                         is_jal,
    input  wire logic                         is_jalr,
    input  wire logic [rv_core_pkg::xlen-1:0] alu_result,
    input  wire logic [rv_core_pkg::xlen-1:0] snpc,
    input  wire logic [rv_core_pkg::xlen-1:0] rdata2,
    input  wire logic [rv_core_pkg::xlen-1:0] dmem_rdata,
    output logic                              dmem_req,
    output logic                              dmem_we,
    output logic [rv_core_pkg::xlen-1:0]      dmem_addr,
    output logic [rv_core_pkg::xlen-1:0]      dmem_wdata,
    output logic                              rf_we,
    output logic [rv_core_pkg::xlen-1:0]      rf_wdata,
    output logic                              retire,
    output logic                              done
);

    logic load_q;   // LOAD state, exec is still high here

    always_ff @(posedge clk) begin
        if (reset)
            load_q <= 1'b0;
        else
            load_q <= exec && is_load && !load_q;
    end

    // issue only in the first exec cycle
    assign dmem_req   = exec && !load_q && (is_load || is_store);
    assign dmem_we    = exec && !load_q && is_store;
    assign dmem_addr  = alu_result;
    assign dmem_wdata = rdata2;

    assign done     = (exec && !is_load) || load_q;
    assign retire   = done;
    assign rf_we    = done && writes_rd;
    assign rf_wdata = load_q ? dmem_rdata :
                      (is_jal || is_jalr) ? snpc : alu_result;

endmodule

`default_nettype wire

//--- hdl/execute_unit.sv
/* operand select, branch compare and next-pc forming
   jalr target has bit 0 cleared; no misalignment trap */
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  wire logic [rv_core_pkg::xlen-1:0] pc,
    input  wire logic [rv_core_pkg::xlen-1:0] imm,
    input  wire logic [rv_core_pkg::xlen-1:0] rdata1,
    input  wire logic [rv_core_pkg::xlen-1:0] rdata2,
    input  wire rv_core_pkg::alu_op_t         alu_op,
    input  wire logic [2:0]                   funct3,
    input  wire logic                         is_branch,
    input  wire logic                         is_jal,
    input  wire logic                         is_jalr,
    input  wire logic                         is_lui,
    input  wire logic                         is_auipc,
    input  wire logic                         use_imm,
    output logic [rv_core_pkg::xlen-1:0]      alu_result,
    output logic [rv_core_pkg::xlen-1:0]      next_pc,
    output logic [rv_core_pkg::xlen-1:0]      snpc
);
    import rv_core_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic            taken;

    assign op_a = (is_auipc || is_jal || is_branch) ? pc :
                  is_lui ? '0 : rdata1;
    assign op_b = use_imm ? imm : rdata2;

    alu u_alu (
        .op     (alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result)
    );

    always_comb begin
        case (funct3)
            f3_beq:  taken = (rdata1 == rdata2);
            f3_bne:  taken = (rdata1 != rdata2);
            f3_blt:  taken = ($signed(rdata1) < $signed(rdata2));
            f3_bge:  taken = ($signed(rdata1) >= $signed(rdata2));
            f3_bltu: taken = (rdata1 < rdata2);
            f3_bgeu: taken = (rdata1 >= rdata2);
            default: taken = 1'b0;   // 010/011 are not branches
        endcase
    end

    assign snpc = pc + 32'd4;

    always_comb begin
        if (is_jal || (is_branch && taken))
            next_pc = alu_result;
        else if (is_jalr)
            next_pc = {alu_result[xlen-1:1], 1'b0};
        else
            next_pc = snpc;
    end

endmodule

`default_nettype wire

//--- hdl/alu.sv
/* integer alu for the ten rv32i operations
   shift amount is b[4:0], upper bits ignored */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire rv_core_pkg::alu_op_t             op,
    input  wire logic [rv_core_pkg::xlen-1:0]     a,
    input  wire logic [rv_core_pkg::xlen-1:0]     b,
    output logic [rv_core_pkg::xlen-1:0]          result
);
    import rv_core_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: result = {{(xlen-1){1'b0}}, a < b};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $unsigned($signed(a) >>> shamt);  // keeps sign
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
/* 32 x 32 integer registers; x0 reads zero and drops writes
   reads are combinational, write lands at the clock edge */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic                               clk,
    input  wire logic                               reset,
    input  wire logic                               we,
    input  wire logic [rv_core_pkg::reg_addr_w-1:0] waddr,
    input  wire logic [rv_core_pkg::xlen-1:0]       wdata,
    input  wire logic [rv_core_pkg::reg_addr_w-1:0] raddr1,
    input  wire logic [rv_core_pkg::reg_addr_w-1:0] raddr2,
    output logic [rv_core_pkg::xlen-1:0]            rdata1,
    output logic [rv_core_pkg::xlen-1:0]            rdata2
);
    import rv_core_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**reg_addr_w; i++)
                regs[i] <= '0;
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- hdl/decode_unit.sv
/* combinational decode of the latched word; funct3 goes straight to execute
   unsupported opcodes come out with every class flag and writes_rd clear */
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  wire rv_core_pkg::inst_u               inst,
    output logic [rv_core_pkg::reg_addr_w-1:0]    rs1,
    output logic [rv_core_pkg::reg_addr_w-1:0]    rs2,
    output logic [rv_core_pkg::reg_addr_w-1:0]    rd,
    output logic [rv_core_pkg::xlen-1:0]          imm,
    output rv_core_pkg::alu_op_t                  alu_op,
    output logic                                  is_branch,
    output logic                                  is_jal,
    output logic                                  is_jalr,
    output logic                                  is_load,
    output logic                                  is_store,
    output logic                                  is_lui,
    output logic                                  is_auipc,
    output logic                                  writes_rd,
    output logic                                  use_imm
);
    import rv_core_pkg::*;

    logic [6:0] opcode;
    logic       is_reg;
    logic       is_imm;

    assign opcode = inst.r_fmt.opcode;
    assign rs1    = inst.r_fmt.rs1;
    assign rs2    = inst.r_fmt.rs2;
    assign rd     = inst.r_fmt.rd;

    assign is_reg    = (opcode == op_reg);
    assign is_imm    = (opcode == op_imm);
    assign is_load   = (opcode == op_load);
    assign is_store  = (opcode == op_store);
    assign is_branch = (opcode == op_branch);
    assign is_jal    = (opcode == op_jal);
    assign is_jalr   = (opcode == op_jalr);
    assign is_lui    = (opcode == op_lui);
    assign is_auipc  = (opcode == op_auipc);

    assign writes_rd = is_reg | is_imm | is_load | is_jal | is_jalr | is_lui | is_auipc;
    assign use_imm   = !is_reg;   // branches add imm to pc

    // sign-extended immediate per format
    always_comb begin
        case (opcode)
            op_imm, op_load, op_jalr:
                imm = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
            op_store:
                imm = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
            op_branch:
                imm = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                       inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
            op_lui, op_auipc:
                imm = {inst.u_fmt.imm_31_12, 12'b0};
            op_jal:
                imm = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                       inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
            default:
                imm = '0;
        endcase
    end

    // everything but reg/imm arithmetic is an add
    always_comb begin
        alu_op = alu_add;
        if (is_reg || is_imm) begin
            case (inst.r_fmt.funct3)
                3'b000:  alu_op = (is_reg && inst.r_fmt.funct7[5]) ? alu_sub : alu_add;
                3'b001:  alu_op = alu_sll;
                3'b010:  alu_op = alu_slt;
                3'b011:  alu_op = alu_sltu;
                3'b100:  alu_op = alu_xor;
                3'b101:  alu_op = inst.r_fmt.funct7[5] ? alu_sra : alu_srl;  // srai too
                3'b110:  alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
/* pc and phase sequencer; imem must answer exactly one cycle after imem_req
   imem_req stays low on the first cycle after reset and fires on the second */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter logic [rv_core_pkg::xlen-1:0] reset_pc = 32'h8000_0000
) (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         done,
    input  wire logic [rv_core_pkg::xlen-1:0] next_pc,
    input  wire logic [rv_core_pkg::xlen-1:0] imem_rdata,
    output logic                              imem_req,
    output logic [rv_core_pkg::xlen-1:0]      imem_addr,
    output logic [rv_core_pkg::xlen-1:0]      pc,
    output rv_core_pkg::inst_u                inst,
    output logic                              exec
);

    typedef enum logic [1:0] {
        ph_fetch,
        ph_wait,
        ph_exec
    } phase_t;

    phase_t phase, phase_nxt;

    always_comb begin
        phase_nxt = phase;
        case (phase)
            ph_fetch: if (imem_req) phase_nxt = ph_wait;
            ph_wait:  phase_nxt = ph_exec;       // word arrives this cycle
            ph_exec:  if (done) phase_nxt = ph_fetch;
            default:  phase_nxt = ph_fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase    <= ph_fetch;
            imem_req <= 1'b0;
            pc       <= reset_pc;
        end else begin
            phase    <= phase_nxt;
            imem_req <= (phase_nxt == ph_fetch);   // one pulse per fetch
            if (done)
                pc <= next_pc;
        end
    end

    // instruction word latch
    always_ff @(posedge clk) begin
        if (phase == ph_wait)
            inst <= imem_rdata;
    end

    assign imem_addr = pc;
    assign exec      = (phase == ph_exec);   // stays high through a load

endmodule

`default_nettype wire

//--- hdl/rv_core_pkg.sv
/* shared widths, encodings and the instruction-format union for the RV32I core
   only the opcodes listed here are decoded; anything else retires as a no-op */
`default_nettype none

package rv_core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // base opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;

    // branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_t;

    // field layouts, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

endpackage

`default_nettype wire
